// File: Bender.yml
# Receive side of a NoC endpoint with class-based channel demux.
package:
  name: noc_rx

sources:
  # Packages first, the RTL depends on both.
  - source/noc_flit_pkg.sv
  - source/noc_route_pkg.sv

  # RTL, leaf modules before the top level.
  - source/noc_buffer.sv
  - source/noc_demux.sv
  - source/noc_rx_top.sv

  # Testbench, only for simulation.
  - target: test
    files:
      - verification/tb_noc_rx.sv

// File: noc_rx.f
source/noc_flit_pkg.sv
source/noc_route_pkg.sv
source/noc_buffer.sv
source/noc_demux.sv
source/noc_rx_top.sv
verification/tb_noc_rx.sv

// File: source/noc_buffer.sv
// Flit FIFO with valid/ready on both sides, DEPTH a power of two and at least 2.
// No combinational path from input to output; a written flit shows one cycle later.
`timescale 1ns/10ps

module noc_buffer #(
   parameter int DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst,

   // Write side.
   input  noc_flit_pkg::noc_flit_t in_flit,
   input  logic                  in_last,
   input  logic                  in_valid,
   output logic                  in_ready,

   // Read side.
   output noc_flit_pkg::noc_flit_t out_flit,
   output logic                  out_last,
   output logic                  out_valid,
   input  logic                  out_ready
);

   import noc_flit_pkg::*;

   localparam int AW = $clog2(DEPTH); // Index bits, the pointers carry one more.

   // Flit and last bit stored side by side, last in the top bit.
   logic [FLIT_WIDTH:0] mem [DEPTH];

   logic [AW:0] wr_ptr; // Extra MSB is the wrap bit.
   logic [AW:0] rd_ptr;
   logic [AW:0] count;  // Occupancy from the pointer difference.
   logic        full;
   logic        empty;
   logic        wr_en;
   logic        rd_en;

   if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_bad_depth
      $error("noc_buffer: DEPTH must be a power of two and at least 2");
   end

   // Same index, different wrap bit means one full lap ahead.
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign empty = (wr_ptr == rd_ptr);
   assign count = wr_ptr - rd_ptr;

   assign in_ready  = !full;  // Only a full buffer pushes back.
   assign out_valid = !empty;

   assign wr_en = in_valid && in_ready; // Handshake on each side.
   assign rd_en = out_valid && out_ready;

   // Storage, written on each accepted flit.
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[AW-1:0]] <= {in_last, in_flit};
      end
   end

   // Head of the queue is always presented.
   assign {out_last, out_flit} = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1; // Wraps naturally through the extra bit.
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // A write into a full buffer would push the occupancy past DEPTH.
   a_no_write_when_full : assert property (
      @(posedge clk) disable iff (rst)
      (count == DEPTH) |=> (count <= DEPTH)
   ) else $error("noc_buffer: write accepted while full");

   // A read from an empty buffer would wrap the occupancy below zero.
   a_no_read_when_empty : assert property (
      @(posedge clk) disable iff (rst)
      (count == 0) |=> (count <= 1)
   ) else $error("noc_buffer: read taken while empty");

endmodule

// File: source/noc_demux.sv
// Class demultiplexer, combinational from input to outputs.
// A stalled channel stalls the whole input; the lock only moves on a real transfer.
`timescale 1ns/10ps

module noc_demux #(
   parameter int                        CHANNELS = 2,
   parameter noc_route_pkg::class_map_t MAPPING  = noc_route_pkg::DEFAULT_MAP
) (
   input  logic                                  clk,
   input  logic                                  rst,

   // Single input link from the input buffer.
   input  noc_flit_pkg::noc_flit_t                in_flit,
   input  logic                                  in_last,
   input  logic                                  in_valid,
   output logic                                  in_ready,

   // One link per channel.
   output noc_flit_pkg::noc_flit_t [CHANNELS-1:0] out_flit,
   output logic [CHANNELS-1:0]                   out_last,
   output logic [CHANNELS-1:0]                   out_valid,
   input  logic [CHANNELS-1:0]                   out_ready
);

   import noc_flit_pkg::*;
   import noc_route_pkg::*;

   logic [CLASS_W-1:0]      pclass;     // Class from the header view.
   logic [MAX_CHANNELS-1:0] class_byte; // Table entry for that class.
   logic [CHANNELS-1:0]     select;     // Channel chosen for a new packet.
   logic [CHANNELS-1:0]     active;     // Locked channel, zero when idle.
   logic [CHANNELS-1:0]     nxt_active;
   logic [CHANNELS-1:0]     route;      // Channel this cycle's flit goes to.
   logic                    xfer;

   if (CHANNELS < 2 || CHANNELS > MAX_CHANNELS) begin : g_bad_channels
      $error("noc_demux: CHANNELS must be between 2 and MAX_CHANNELS");
   end

   // Only meaningful on a header flit; ignored while a packet is locked.
   assign pclass = in_flit.hdr.pclass;

   // Each class owns one MAX_CHANNELS wide slot, i.e. one byte of the table.
   assign class_byte = MAPPING[pclass*MAX_CHANNELS +: MAX_CHANNELS];

   always_comb begin
      select = class_byte[CHANNELS-1:0]; // Channels beyond CHANNELS are dropped.
      if (select == '0) begin
         select = CHANNELS'(1); // Unmapped class falls back to channel 0.
      end
   end

   // Locked packets ignore the class field, body flits have none.
   assign route = (active != '0) ? active : select;

   // Data fans out to every channel, valid only to the routed one.
   assign out_flit  = {CHANNELS{in_flit}};
   assign out_last  = {CHANNELS{in_last}};
   assign out_valid = route & {CHANNELS{in_valid}};

   assign in_ready = |(route & out_ready); // Follows the routed channel only.
   assign xfer     = in_valid && in_ready;

   always_comb begin
      nxt_active = active;
      if (xfer) begin
         if (active == '0) begin
            // Header of a multi-flit packet takes the lock.
            if (!in_last) begin
               nxt_active = select;
            end
         end else if (in_last) begin
            nxt_active = '0; // Tail frees the demux for the next header.
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= '0;
      end else begin
         active <= nxt_active;
      end
   end

   // Never offer one flit to two consumers.
   a_valid_onehot0 : assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(out_valid)
   ) else $error("noc_demux: flit offered on more than one channel");

   // Catches a MAPPING entry with more than one bit set in the used range.
   a_select_onehot : assert property (
      @(posedge clk) disable iff (rst)
      in_valid |-> $onehot(select)
   ) else $error("noc_demux: class mapping is not one-hot");

endmodule

// File: source/noc_flit_pkg.sv
// Flit format of the NoC link, one 32-bit word per flit.
// Only the first flit of a packet carries a header; later flits are raw payload.
package noc_flit_pkg;

   localparam int FLIT_WIDTH = 32; // Width of one flit on every link.

   // Header field widths, MSB first in the flit.
   localparam int DEST_W  = 5;  // Destination endpoint.
   localparam int CLASS_W = 3;  // Packet class, used for channel routing.
   localparam int SRC_W   = 5;  // Source endpoint.
   localparam int RSVD_W  = FLIT_WIDTH - DEST_W - CLASS_W - SRC_W; // Spare bits.

   // Header view of the first flit.
   // Resulting positions are dest [31:27], pclass [26:24], src [23:19].
   typedef struct packed {
      logic [DEST_W-1:0]  dest;     // Target endpoint id.
      logic [CLASS_W-1:0] pclass;   // Selects the output channel.
      logic [SRC_W-1:0]   src;      // Sending endpoint id.
      logic [RSVD_W-1:0]  reserved; // Not decoded by the receiver.
   } noc_header_t;

   // The same word seen two ways.
   // A header flit is decoded through hdr, any later flit only through payload,
   // so payload bits that happen to sit at [26:24] mean nothing to routing.
   typedef union packed {
      noc_header_t            hdr;     // First flit of a packet.
      logic [FLIT_WIDTH-1:0]  payload; // Body flits.
   } noc_flit_t;

endpackage

// File: source/noc_route_pkg.sv
// Class to channel routing description, fixed at elaboration.
// Each class maps to one channel or to none; unmapped classes fall back to channel 0.
package noc_route_pkg;

   localparam int NUM_CLASSES  = 8; // One per value of the 3-bit class field.
   localparam int MAX_CHANNELS = 8; // One table byte holds a mask for this many.

   // Mapping table, one byte per class.
   // Byte k is the channel bitmask for class k, bit c selects channel c.
   // Only the low CHANNELS bits of a byte are looked at.
   // A mask is one-hot, or zero for an unmapped class.
   typedef logic [NUM_CLASSES*MAX_CHANNELS-1:0] class_map_t;

   // Default table for a two channel receiver.
   //   class 0, 1  -> channel 0
   //   class 2, 3  -> channel 1
   //   class 4..7  -> unmapped, so channel 0 by fallback
   localparam class_map_t DEFAULT_MAP = {
      8'h00, // Class 7.
      8'h00, // Class 6.
      8'h00, // Class 5.
      8'h00, // Class 4.
      8'h02, // Class 3.
      8'h02, // Class 2.
      8'h01, // Class 1.
      8'h01  // Class 0.
   };

endpackage

// File: source/noc_rx_top.sv
// Receive side of a NoC endpoint: input buffer, class demux, one buffer per channel.
// Earliest input to output latency is two cycles; back-pressure on one channel stalls all.
`timescale 1ns/10ps

module noc_rx_top #(
   parameter int                        CHANNELS  = 2,
   parameter noc_route_pkg::class_map_t MAPPING   = noc_route_pkg::DEFAULT_MAP,
   parameter int                        IN_DEPTH  = 4,
   parameter int                        OUT_DEPTH = 4
) (
   input  logic                                  clk,
   input  logic                                  rst,

   // Link from the router.
   input  noc_flit_pkg::noc_flit_t                in_flit,
   input  logic                                  in_last,
   input  logic                                  in_valid,
   output logic                                  in_ready,

   // Links to the local consumers, indexed by channel.
   output noc_flit_pkg::noc_flit_t [CHANNELS-1:0] out_flit,
   output logic [CHANNELS-1:0]                   out_last,
   output logic [CHANNELS-1:0]                   out_valid,
   input  logic [CHANNELS-1:0]                   out_ready
);

   import noc_flit_pkg::*;

   // Input buffer to demux.
   noc_flit_t buf_flit;
   logic      buf_last;
   logic      buf_valid;
   logic      buf_ready;

   // Demux to output buffers.
   noc_flit_t [CHANNELS-1:0] dmx_flit;
   logic [CHANNELS-1:0]      dmx_last;
   logic [CHANNELS-1:0]      dmx_valid;
   logic [CHANNELS-1:0]      dmx_ready;

   // Decouples the router from the demux, adds one cycle.
   noc_buffer #(
      .DEPTH (IN_DEPTH)
   ) u_in_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (buf_flit),
      .out_last  (buf_last),
      .out_valid (buf_valid),
      .out_ready (buf_ready)
   );

   // Zero latency, holds each packet on one channel.
   noc_demux #(
      .CHANNELS (CHANNELS),
      .MAPPING  (MAPPING)
   ) u_demux (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (buf_flit),
      .in_last   (buf_last),
      .in_valid  (buf_valid),
      .in_ready  (buf_ready),
      .out_flit  (dmx_flit),
      .out_last  (dmx_last),
      .out_valid (dmx_valid),
      .out_ready (dmx_ready)
   );

   // One buffer per consumer, adds the second cycle.
   for (genvar c = 0; c < CHANNELS; c++) begin : g_out
      noc_buffer #(
         .DEPTH (OUT_DEPTH)
      ) u_out_buf (
         .clk       (clk),
         .rst       (rst),
         .in_flit   (dmx_flit[c]),
         .in_last   (dmx_last[c]),
         .in_valid  (dmx_valid[c]),
         .in_ready  (dmx_ready[c]),
         .out_flit  (out_flit[c]),
         .out_last  (out_last[c]),
         .out_valid (out_valid[c]),
         .out_ready (out_ready[c])
      );
   end

endmodule

// File: verification/tb_noc_rx.sv
// Testbench for noc_rx_top with two channels and the default class mapping.
// Expected channels come from a local class mask table.
`timescale 1ns/10ps

module tb_noc_rx;

   import noc_flit_pkg::*;
   import noc_route_pkg::*;

   localparam int CHANNELS    = 2;
   localparam int TIMEOUT     = 1000; // Cycles allowed for any single wait.
   localparam int STALL_LIMIT = 64;   // Flits offered before in_ready must drop.
   localparam int NROWS       = 12;

   localparam int READY_ALL    = 0; // Consumers always ready.
   localparam int READY_RANDOM = 1; // Consumers ready at random.
   localparam int READY_NONE   = 2; // Consumers stalled.

   // Channel mask per class, index is the class.
   localparam logic [7:0] CLASS_MASK [NUM_CLASSES] = '{
      8'h01, 8'h01, 8'h02, 8'h02, 8'h00, 8'h00, 8'h00, 8'h00
   };

   // Stimulus rows: {class, length, payload base}.
   // Several bases carry bits [26:24] that would name another class in a header.
   localparam logic [39:0] STIM [NROWS] = '{
      {4'd0, 4'd1, 32'h0000_1000},
      {4'd1, 4'd3, 32'h0200_2000}, // Body looks like class 2.
      {4'd2, 4'd4, 32'h0000_3000}, // Body looks like class 0.
      {4'd3, 4'd2, 32'h0100_4000},
      {4'd4, 4'd1, 32'h0000_5000},
      {4'd5, 4'd2, 32'h0300_6000}, // Unmapped, body looks like class 3.
      {4'd6, 4'd4, 32'h0200_7000},
      {4'd7, 4'd3, 32'h0600_8000},
      {4'd2, 4'd1, 32'h0000_9000},
      {4'd3, 4'd4, 32'h0700_a000},
      {4'd0, 4'd2, 32'h0300_b000}, // Channel 0 packet, body looks like class 3.
      {4'd1, 4'd1, 32'h0000_c000}
   };

   logic                     clk = 1'b0;
   logic                     rst;
   noc_flit_t                in_flit;
   logic                     in_last;
   logic                     in_valid;
   logic                     in_ready;
   noc_flit_t [CHANNELS-1:0] out_flit;
   logic [CHANNELS-1:0]      out_last;
   logic [CHANNELS-1:0]      out_valid;
   logic [CHANNELS-1:0]      out_ready;

   integer              seed = 3402;  // Seed for back-pressure.
   int                  ready_mode;
   logic [FLIT_WIDTH:0] exp_q [CHANNELS][$]; // {last, flit} per channel.
   logic [FLIT_WIDTH:0] mon_exp;
   int                  sent;

   noc_rx_top #(
      .CHANNELS  (CHANNELS),
      .MAPPING   (DEFAULT_MAP),
      .IN_DEPTH  (4),
      .OUT_DEPTH (4)
   ) uut (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #10 clk = ~clk; // 20 ns period.

   // Stops the run with a reason line first.
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [FLIT_WIDTH-1:0] expected,
                              input logic [FLIT_WIDTH-1:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual));
      end
   endtask

   // Mask limited to the real channels, empty mask falls back to channel 0.
   function automatic int expected_channel(input logic [2:0] cls);
      logic [7:0] mask;
      int         ch;
      mask = CLASS_MASK[cls] & 8'((1 << CHANNELS) - 1);
      ch   = 0;
      for (int c = 0; c < CHANNELS; c++) begin
         if (mask[c]) ch = c;
      end
      return ch;
   endfunction

   function automatic logic queues_empty();
      logic empty;
      empty = 1'b1;
      for (int c = 0; c < CHANNELS; c++) begin
         if (exp_q[c].size() != 0) empty = 1'b0;
      end
      return empty;
   endfunction

   // Out_ready changes 1 ns after each rising edge.
   always @(posedge clk) begin
      #1;
      case (ready_mode)
         READY_RANDOM: out_ready = CHANNELS'($random(seed));
         READY_NONE:   out_ready = '0;
         default:      out_ready = '1;
      endcase
   end

   // Mode is switched at the falling edge, so it is settled by the next drive.
   task automatic set_ready_mode(input int mode);
      @(negedge clk);
      ready_mode = mode;
      @(posedge clk);
      #1;
   endtask

   // Called 1 ns after a rising edge; returns 1 ns after the accepting edge.
   task automatic send_flit(input noc_flit_t flit, input logic last);
      int waited;
      waited   = 0;
      in_flit  = flit;
      in_last  = last;
      in_valid = 1'b1;
      @(negedge clk); // In_ready is stable between edges.
      while (!in_ready) begin
         waited++;
         if (waited > TIMEOUT) abort_run("Timeout waiting for in_ready on the input link");
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   // Header first, then payload words counting up from base.
   task automatic send_packet(input logic [2:0] cls, input int len,
                              input logic [FLIT_WIDTH-1:0] base, input int tag);
      noc_flit_t flit;
      logic      last;
      int        ch;
      ch = expected_channel(cls);
      for (int k = 0; k < len; k++) begin
         if (k == 0) begin
            flit.hdr.dest     = 5'(tag);
            flit.hdr.pclass   = cls;
            flit.hdr.src      = 5'h1b;
            flit.hdr.reserved = base[RSVD_W-1:0];
         end else begin
            flit.payload = base + FLIT_WIDTH'(k - 1);
         end
         last = (k == len - 1);
         exp_q[ch].push_back({last, flit.payload}); // Expected before it can arrive.
         send_flit(flit, last);
      end
   endtask

   task automatic run_table();
      for (int r = 0; r < NROWS; r++) begin
         send_packet(STIM[r][38:36], int'(STIM[r][35:32]), STIM[r][31:0], r);
      end
   endtask

   // Queues only change at the falling edge, so poll on the rising one.
   task automatic wait_drain(input string phase);
      int waited;
      waited = 0;
      while (!queues_empty()) begin
         waited++;
         if (waited > TIMEOUT) abort_run($sformatf("Timeout draining flits after %s", phase));
         @(posedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   // Scoreboard, outputs are stable at the falling edge.
   always @(negedge clk) begin
      if (rst) begin
         check_value("out_valid", '0, FLIT_WIDTH'(out_valid)); // Quiet during reset.
      end else begin
         for (int c = 0; c < CHANNELS; c++) begin
            if (out_valid[c] && out_ready[c]) begin
               if (exp_q[c].size() == 0) begin
                  abort_run($sformatf("Flit on channel %0d with no flit expected there", c));
               end else begin
                  mon_exp = exp_q[c].pop_front();
                  check_value($sformatf("out_flit[%0d]", c), mon_exp[FLIT_WIDTH-1:0],
                              out_flit[c].payload);
                  check_value($sformatf("out_last[%0d]", c), FLIT_WIDTH'(mon_exp[FLIT_WIDTH]),
                              FLIT_WIDTH'(out_last[c]));
               end
            end
         end
      end
   end

   initial begin
      rst        = 1'b1;
      in_flit    = '0;
      in_last    = 1'b0;
      in_valid   = 1'b0;
      out_ready  = '1;
      ready_mode = READY_ALL;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      // Empty after reset.
      @(negedge clk);
      check_value("out_valid", '0, FLIT_WIDTH'(out_valid));
      check_value("in_ready", 1, FLIT_WIDTH'(in_ready));
      @(posedge clk);
      #1;

      // Routing, fallback and atomicity with free-running consumers.
      run_table();
      wait_drain("class routing");

      // Same traffic under random back-pressure, twice over.
      set_ready_mode(READY_RANDOM);
      run_table();
      run_table();
      wait_drain("random back-pressure");
      set_ready_mode(READY_ALL);

      // Full stall: single-flit packets until the input pushes back.
      set_ready_mode(READY_NONE);
      sent = 0;
      while (in_ready) begin
         if (sent > STALL_LIMIT) abort_run("in_ready stayed high with every channel stalled");
         send_packet(3'(sent), 1, FLIT_WIDTH'(32'h00d0_0000 + sent), sent);
         sent++;
      end
      repeat (4) @(posedge clk);
      #1;
      check_value("in_ready", 0, FLIT_WIDTH'(in_ready)); // Still held off.
      set_ready_mode(READY_ALL);
      wait_drain("full stall");

      // Nothing stray may follow.
      repeat (8) @(posedge clk);
      #1;
      check_value("out_valid", '0, FLIT_WIDTH'(out_valid));
      $display("TEST OK");
      $finish;
   end

endmodule
